// ==== src/rv_isa_pkg.sv ====
package rv_isa_pkg;

   localparam int XLEN       = 32;
   localparam int REG_ADDR_W = 5;

   // major opcodes, bits 6:2 of the instruction
   localparam logic [4:0] OPC_OP     = 5'b01100;
   localparam logic [4:0] OPC_OP_IMM = 5'b00100;
   localparam logic [4:0] OPC_LUI    = 5'b01101;
   localparam logic [4:0] OPC_LOAD   = 5'b00000;
   localparam logic [4:0] OPC_STORE  = 5'b01000;
   localparam logic [4:0] OPC_BRANCH = 5'b11000;
   localparam logic [4:0] OPC_JAL    = 5'b11011;

   // register and immediate ALU ops
   localparam logic [2:0] F3_ADD_SUB = 3'b000;
   localparam logic [2:0] F3_SLT     = 3'b010;
   localparam logic [2:0] F3_XOR     = 3'b100;
   localparam logic [2:0] F3_OR      = 3'b110;
   localparam logic [2:0] F3_AND     = 3'b111;

   // memory access width
   localparam logic [2:0] F3_BYTE    = 3'b000; // sb
   localparam logic [2:0] F3_BYTE_U  = 3'b100; // lbu, zero extended
   localparam logic [2:0] F3_WORD    = 3'b010;

   // branches
   localparam logic [2:0] F3_BEQ     = 3'b000;
   localparam logic [2:0] F3_BNE     = 3'b001;

   localparam logic [6:0] F7_SUB     = 7'b0100000;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT,
      ALU_PASS_B // lui
   } alu_op_e;

endpackage

// ==== src/core_pipe_pkg.sv ====
package core_pipe_pkg;

   import rv_isa_pkg::*;

   typedef enum logic [1:0] {
      WB_ALU,
      WB_LOAD,
      WB_PC4 // link value of jal
   } wb_sel_e;

   typedef struct packed {
      logic        valid;
      logic [29:0] pc;
      logic [29:0] instr; // low two bits are always 2'b11
   } if_id_t;

   typedef struct packed {
      logic                  valid;
      logic [29:0]           pc;
      logic [REG_ADDR_W-1:0] rs1;
      logic [REG_ADDR_W-1:0] rs2;
      logic [XLEN-1:0]       rs1_val;
      logic [XLEN-1:0]       rs2_val;
      logic [XLEN-1:0]       imm;
      logic [REG_ADDR_W-1:0] rd;
      alu_op_e               alu_op;
      logic                  op1_is_pc;
      logic                  op2_is_imm;
      logic                  is_branch;
      logic                  branch_ne;
      logic                  is_jal;
      logic                  is_load;
      logic                  is_store;
      logic                  store_byte; // byte wide access, load or store
      logic                  wb_en;
      wb_sel_e               wb_sel;
   } id_ex_t;

   typedef struct packed {
      logic                  valid;
      logic [29:0]           pc;
      logic [XLEN-1:0]       alu_out;
      logic [XLEN-1:0]       store_data;
      logic [REG_ADDR_W-1:0] rd;
      logic                  is_load;
      logic                  is_store;
      logic                  store_byte;
      logic                  wb_en;
      wb_sel_e               wb_sel;
   } ex_mem_t;

   typedef struct packed {
      logic                  valid;
      logic [REG_ADDR_W-1:0] rd;
      logic                  wb_en;
      logic [XLEN-1:0]       wb_data;
   } mem_wb_t;

endpackage

// ==== src/pipe_reg.sv ====
`timescale 1ns/1ps

module pipe_reg import core_pipe_pkg::*; #(
   parameter type payload_t = if_id_t
) (
   input  logic     clk_i,
   input  logic     arst_n_i,
   input  logic     advance_i,
   input  logic     bubble_i,
   input  payload_t d_i,
   output payload_t q_o
);

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         q_o <= '0;
      end else if (advance_i) begin
         q_o <= d_i;
         if (bubble_i) begin
            q_o.valid <= 1'b0; // slot becomes a nop
         end
      end
      // no advance, hold the slot
   end

endmodule

// ==== src/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage import core_pipe_pkg::*; (
   input  logic        clk_i,
   input  logic        arst_n_i,
   input  logic        hold_i,
   input  logic        redirect_i,
   input  logic [29:0] redirect_pc_i,
   input  logic [29:0] icache_instr_i,
   input  logic        icache_blocking_n_i,
   output logic [29:0] icache_addr_o,
   output if_id_t      if_id_o
);

   logic [29:0] pc_q; // word address

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         pc_q <= '0;
      end else if (!hold_i) begin
         if (redirect_i) begin
            pc_q <= redirect_pc_i;
         end else if (icache_blocking_n_i) begin
            pc_q <= pc_q + 30'd1;
         end
      end
   end

   assign icache_addr_o = pc_q;

   // wrong path or missing instruction goes down as a bubble
   always_comb begin
      if_id_o.valid = icache_blocking_n_i & ~redirect_i;
      if_id_o.pc    = pc_q;
      if_id_o.instr = icache_instr_i;
   end

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/1ps

module reg_file import rv_isa_pkg::*; (
   input  logic                  clk_i,
   input  logic                  arst_n_i,
   input  logic [REG_ADDR_W-1:0] rs1_i,
   input  logic [REG_ADDR_W-1:0] rs2_i,
   input  logic [REG_ADDR_W-1:0] rd_i,
   input  logic                  wr_en_i,
   input  logic [XLEN-1:0]       wr_data_i,
   output logic [XLEN-1:0]       rs1_data_o,
   output logic [XLEN-1:0]       rs2_data_o
);

   logic [XLEN-1:0] regs_q [1:31]; // x0 is not stored

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int i = 1; i < 32; i++) begin
            regs_q[i] <= '0;
         end
      end else if (wr_en_i && rd_i != '0) begin
         regs_q[rd_i] <= wr_data_i;
      end
   end

   // write-through so write-back and decode can share a cycle
   assign rs1_data_o = (rs1_i == '0) ? '0 :
                       (wr_en_i && rd_i == rs1_i) ? wr_data_i : regs_q[rs1_i];
   assign rs2_data_o = (rs2_i == '0) ? '0 :
                       (wr_en_i && rd_i == rs2_i) ? wr_data_i : regs_q[rs2_i];

endmodule

// ==== src/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage import rv_isa_pkg::*, core_pipe_pkg::*; (
   input  logic    clk_i,
   input  logic    arst_n_i,
   input  if_id_t  if_id_i,
   input  id_ex_t  id_ex_q_i,
   input  mem_wb_t mem_wb_i,
   output id_ex_t  id_ex_o,
   output logic    load_stall_o
);

   logic [31:0]     instr;
   logic [4:0]      opcode;
   logic [2:0]      funct3;
   logic [XLEN-1:0] imm_i;
   logic [XLEN-1:0] imm_s;
   logic [XLEN-1:0] imm_b;
   logic [XLEN-1:0] imm_u;
   logic [XLEN-1:0] imm_j;
   logic [XLEN-1:0] rs1_data;
   logic [XLEN-1:0] rs2_data;
   logic            known;

   assign instr  = {if_id_i.instr, 2'b11};
   assign opcode = instr[6:2];
   assign funct3 = instr[14:12];

   assign imm_i = {{20{instr[31]}}, instr[31:20]};
   assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
   assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
   assign imm_u = {instr[31:12], 12'b0};
   assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

   reg_file u_rf (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .rs1_i      (instr[19:15]),
      .rs2_i      (instr[24:20]),
      .rd_i       (mem_wb_i.rd),
      .wr_en_i    (mem_wb_i.valid & mem_wb_i.wb_en),
      .wr_data_i  (mem_wb_i.wb_data),
      .rs1_data_o (rs1_data),
      .rs2_data_o (rs2_data)
   );

   always_comb begin
      id_ex_o         = '0;
      id_ex_o.pc      = if_id_i.pc;
      id_ex_o.rs1     = instr[19:15];
      id_ex_o.rs2     = instr[24:20];
      id_ex_o.rs1_val = rs1_data;
      id_ex_o.rs2_val = rs2_data;
      id_ex_o.rd      = instr[11:7];
      id_ex_o.alu_op  = ALU_ADD;
      id_ex_o.wb_sel  = WB_ALU;
      known           = 1'b1;
      case (opcode)
         OPC_OP: begin
            id_ex_o.wb_en = 1'b1;
            case (funct3)
               F3_ADD_SUB: id_ex_o.alu_op = (instr[31:25] == F7_SUB) ? ALU_SUB : ALU_ADD;
               F3_SLT:     id_ex_o.alu_op = ALU_SLT;
               F3_XOR:     id_ex_o.alu_op = ALU_XOR;
               F3_OR:      id_ex_o.alu_op = ALU_OR;
               F3_AND:     id_ex_o.alu_op = ALU_AND;
               default:    known = 1'b0;
            endcase
         end
         OPC_OP_IMM: begin // addi only
            id_ex_o.wb_en      = 1'b1;
            id_ex_o.op2_is_imm = 1'b1;
            id_ex_o.imm        = imm_i;
            known              = (funct3 == F3_ADD_SUB);
         end
         OPC_LUI: begin
            id_ex_o.wb_en      = 1'b1;
            id_ex_o.op2_is_imm = 1'b1;
            id_ex_o.imm        = imm_u;
            id_ex_o.alu_op     = ALU_PASS_B;
         end
         OPC_LOAD: begin
            id_ex_o.wb_en      = 1'b1;
            id_ex_o.wb_sel     = WB_LOAD;
            id_ex_o.is_load    = 1'b1;
            id_ex_o.op2_is_imm = 1'b1;
            id_ex_o.imm        = imm_i;
            id_ex_o.store_byte = (funct3 == F3_BYTE_U);
            known              = (funct3 == F3_WORD) || (funct3 == F3_BYTE_U);
         end
         OPC_STORE: begin
            id_ex_o.is_store   = 1'b1;
            id_ex_o.op2_is_imm = 1'b1;
            id_ex_o.imm        = imm_s;
            id_ex_o.store_byte = (funct3 == F3_BYTE);
            known              = (funct3 == F3_WORD) || (funct3 == F3_BYTE);
         end
         OPC_BRANCH: begin // alu forms the target
            id_ex_o.is_branch  = 1'b1;
            id_ex_o.branch_ne  = (funct3 == F3_BNE);
            id_ex_o.op1_is_pc  = 1'b1;
            id_ex_o.op2_is_imm = 1'b1;
            id_ex_o.imm        = imm_b;
            known              = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
         end
         OPC_JAL: begin
            id_ex_o.is_jal     = 1'b1;
            id_ex_o.wb_en      = 1'b1;
            id_ex_o.wb_sel     = WB_PC4;
            id_ex_o.op1_is_pc  = 1'b1;
            id_ex_o.op2_is_imm = 1'b1;
            id_ex_o.imm        = imm_j;
         end
         default: known = 1'b0;
      endcase
      id_ex_o.valid = if_id_i.valid & known;
   end

   // load result is not ready for forwarding until it reaches write-back
   assign load_stall_o = if_id_i.valid & id_ex_q_i.valid & id_ex_q_i.is_load &
                         (id_ex_q_i.rd != '0) &
                         ((id_ex_q_i.rd == instr[19:15]) | (id_ex_q_i.rd == instr[24:20]));

endmodule

// ==== src/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage import rv_isa_pkg::*, core_pipe_pkg::*; (
   input  id_ex_t      id_ex_i,
   input  ex_mem_t     ex_mem_q_i,
   input  mem_wb_t     mem_wb_i,
   output ex_mem_t     ex_mem_o,
   output logic        branch_taken_o,
   output logic [29:0] branch_target_o
);

   logic            fwd_ex_ok;
   logic            fwd_wb_ok;
   logic [XLEN-1:0] ex_mem_val;
   logic [XLEN-1:0] rs1_fwd;
   logic [XLEN-1:0] rs2_fwd;
   logic [XLEN-1:0] op_a;
   logic [XLEN-1:0] op_b;
   logic [XLEN-1:0] alu_out;
   logic            equal;

   // rd of zero never forwards, a load in mem is covered by the stall
   assign fwd_ex_ok = ex_mem_q_i.valid & ex_mem_q_i.wb_en & ~ex_mem_q_i.is_load &
                      (ex_mem_q_i.rd != '0);
   assign fwd_wb_ok = mem_wb_i.valid & mem_wb_i.wb_en & (mem_wb_i.rd != '0);

   // jal in mem forwards its link, not the alu result
   assign ex_mem_val = (ex_mem_q_i.wb_sel == WB_PC4) ? {ex_mem_q_i.pc + 30'd1, 2'b00}
                                                     : ex_mem_q_i.alu_out;

   assign rs1_fwd = (fwd_ex_ok && ex_mem_q_i.rd == id_ex_i.rs1) ? ex_mem_val :
                    (fwd_wb_ok && mem_wb_i.rd == id_ex_i.rs1)   ? mem_wb_i.wb_data :
                                                                  id_ex_i.rs1_val;
   assign rs2_fwd = (fwd_ex_ok && ex_mem_q_i.rd == id_ex_i.rs2) ? ex_mem_val :
                    (fwd_wb_ok && mem_wb_i.rd == id_ex_i.rs2)   ? mem_wb_i.wb_data :
                                                                  id_ex_i.rs2_val;

   assign op_a = id_ex_i.op1_is_pc ? {id_ex_i.pc, 2'b00} : rs1_fwd;
   assign op_b = id_ex_i.op2_is_imm ? id_ex_i.imm : rs2_fwd;

   always_comb begin
      case (id_ex_i.alu_op)
         ALU_ADD:    alu_out = op_a + op_b;
         ALU_SUB:    alu_out = op_a - op_b;
         ALU_AND:    alu_out = op_a & op_b;
         ALU_OR:     alu_out = op_a | op_b;
         ALU_XOR:    alu_out = op_a ^ op_b;
         ALU_SLT:    alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
         ALU_PASS_B: alu_out = op_b;
         default:    alu_out = '0;
      endcase
   end

   // compare always on the register operands
   assign equal = (rs1_fwd == rs2_fwd);

   assign branch_taken_o  = id_ex_i.valid &
                            (id_ex_i.is_jal | (id_ex_i.is_branch & (equal ^ id_ex_i.branch_ne)));
   assign branch_target_o = alu_out[31:2]; // pc + imm

   always_comb begin
      ex_mem_o.valid      = id_ex_i.valid;
      ex_mem_o.pc         = id_ex_i.pc;
      ex_mem_o.alu_out    = alu_out;
      ex_mem_o.store_data = rs2_fwd;
      ex_mem_o.rd         = id_ex_i.rd;
      ex_mem_o.is_load    = id_ex_i.is_load;
      ex_mem_o.is_store   = id_ex_i.is_store;
      ex_mem_o.store_byte = id_ex_i.store_byte;
      ex_mem_o.wb_en      = id_ex_i.wb_en;
      ex_mem_o.wb_sel     = id_ex_i.wb_sel;
   end

endmodule

// ==== src/memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage import rv_isa_pkg::*, core_pipe_pkg::*; (
   input  ex_mem_t         ex_mem_i,
   input  logic [XLEN-1:0] dcache_data_i,
   output logic [29:0]     dcache_addr_o,
   output logic [3:0]      dcache_wr_en_o,
   output logic [XLEN-1:0] dcache_data_o,
   output logic            dcache_en_o,
   output mem_wb_t         mem_wb_o
);

   logic [1:0]      lane;
   logic            do_store;
   logic [XLEN-1:0] load_val;
   logic [7:0]      load_byte;

   assign lane     = ex_mem_i.alu_out[1:0];
   assign do_store = ex_mem_i.valid & ex_mem_i.is_store;

   assign dcache_en_o    = ex_mem_i.valid & (ex_mem_i.is_load | ex_mem_i.is_store);
   assign dcache_addr_o  = ex_mem_i.alu_out[31:2];
   assign dcache_wr_en_o = !do_store           ? 4'b0000 :
                           ex_mem_i.store_byte ? (4'b0001 << lane) : 4'b1111;
   // byte copied to every lane, the enable picks one
   assign dcache_data_o  = ex_mem_i.store_byte ? {4{ex_mem_i.store_data[7:0]}}
                                               : ex_mem_i.store_data;

   assign load_byte = dcache_data_i[8*lane +: 8];
   assign load_val  = ex_mem_i.store_byte ? {24'b0, load_byte} : dcache_data_i;

   always_comb begin
      mem_wb_o.valid = ex_mem_i.valid;
      mem_wb_o.rd    = ex_mem_i.rd;
      mem_wb_o.wb_en = ex_mem_i.wb_en;
      case (ex_mem_i.wb_sel)
         WB_LOAD: mem_wb_o.wb_data = load_val;
         WB_PC4:  mem_wb_o.wb_data = {ex_mem_i.pc + 30'd1, 2'b00}; // jal link
         default: mem_wb_o.wb_data = ex_mem_i.alu_out;
      endcase
   end

endmodule

// ==== src/core.sv ====
`timescale 1ns/1ps

module core import rv_isa_pkg::*, core_pipe_pkg::*; (
   input  logic            clk_i,
   input  logic            arst_n_i,
   input  logic            instr_cache_blocking_n_i,
   input  logic            data_cache_blocking_n_i,
   input  logic [31:2]     instr_cache_instr_i,
   input  logic [XLEN-1:0] data_cache_data_i,
   output logic [31:2]     instr_cache_address_o,
   output logic [31:2]     data_cache_address_o,
   output logic [3:0]      data_cache_write_en_o,
   output logic [XLEN-1:0] data_cache_data_o,
   output logic            data_cache_enabled_o
);

   logic        freeze;
   logic        load_stall;
   logic        branch_taken;
   logic [29:0] branch_target;
   if_id_t      if_id_d;
   if_id_t      if_id_q;
   id_ex_t      id_ex_d;
   id_ex_t      id_ex_q;
   ex_mem_t     ex_mem_d;
   ex_mem_t     ex_mem_q;
   mem_wb_t     mem_wb_d;
   mem_wb_t     mem_wb_q;

   assign freeze = ~data_cache_blocking_n_i; // dcache busy, whole pipe waits

   fetch_stage u_if (
      .clk_i               (clk_i),
      .arst_n_i            (arst_n_i),
      .hold_i              (freeze | load_stall),
      .redirect_i          (branch_taken),
      .redirect_pc_i       (branch_target),
      .icache_instr_i      (instr_cache_instr_i),
      .icache_blocking_n_i (instr_cache_blocking_n_i),
      .icache_addr_o       (instr_cache_address_o),
      .if_id_o             (if_id_d)
   );

   pipe_reg #(.payload_t(if_id_t)) u_if_id (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .advance_i (~freeze & ~load_stall),
      .bubble_i  (branch_taken),
      .d_i       (if_id_d),
      .q_o       (if_id_q)
   );

   decode_stage u_id (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .if_id_i      (if_id_q),
      .id_ex_q_i    (id_ex_q),
      .mem_wb_i     (mem_wb_q),
      .id_ex_o      (id_ex_d),
      .load_stall_o (load_stall)
   );

   pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .advance_i (~freeze),
      .bubble_i  (load_stall | branch_taken),
      .d_i       (id_ex_d),
      .q_o       (id_ex_q)
   );

   execute_stage u_ex (
      .id_ex_i         (id_ex_q),
      .ex_mem_q_i      (ex_mem_q),
      .mem_wb_i        (mem_wb_q),
      .ex_mem_o        (ex_mem_d),
      .branch_taken_o  (branch_taken),
      .branch_target_o (branch_target)
   );

   pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .advance_i (~freeze),
      .bubble_i  (1'b0),
      .d_i       (ex_mem_d),
      .q_o       (ex_mem_q)
   );

   memory_stage u_mem (
      .ex_mem_i       (ex_mem_q),
      .dcache_data_i  (data_cache_data_i),
      .dcache_addr_o  (data_cache_address_o),
      .dcache_wr_en_o (data_cache_write_en_o),
      .dcache_data_o  (data_cache_data_o),
      .dcache_en_o    (data_cache_enabled_o),
      .mem_wb_o       (mem_wb_d)
   );

   pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .advance_i (~freeze),
      .bubble_i  (1'b0),
      .d_i       (mem_wb_d),
      .q_o       (mem_wb_q)
   );

endmodule

// ==== testbench/core_checker.sv ====
`timescale 1ns/1ps

module core_checker (
   input logic        clk_i,
   input logic        arst_n_i,
   input logic        blocking_n_i,
   input logic        en_i,
   input logic [29:0] addr_i,
   input logic [3:0]  wr_en_i,
   input logic [31:0] wdata_i
);

   // a write needs a live request
   a_wr_needs_en: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (wr_en_i != 4'b0000) |-> en_i)
      else $error("data cache write enables set without a request");

   // request frozen while the cache blocks
   a_hold_while_blocked: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (en_i && !blocking_n_i) |=>
         (en_i && $stable(addr_i) && $stable(wr_en_i) && $stable(wdata_i)))
      else $error("data cache request changed while the cache was blocking");

   a_addr_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      en_i |-> !$isunknown(addr_i))
      else $error("unknown data cache address on an enabled request");

endmodule

bind core core_checker u_checker (
   .clk_i        (clk_i),
   .arst_n_i     (arst_n_i),
   .blocking_n_i (data_cache_blocking_n_i),
   .en_i         (data_cache_enabled_o),
   .addr_i       (data_cache_address_o),
   .wr_en_i      (data_cache_write_en_o),
   .wdata_i      (data_cache_data_o)
);

// ==== testbench/core_tb.sv ====
`timescale 1ns/1ps

module core_tb;

   typedef struct packed {
      logic [29:0] addr; // word address
      logic [3:0]  be;
      logic [31:0] data;
   } store_t;

   localparam int N_RANDOM = 64;

   logic        clk_i = 1'b0;
   logic        arst_n_i;
   logic        instr_cache_blocking_n_i = 1'b1;
   logic        data_cache_blocking_n_i = 1'b1;
   logic [31:2] instr_cache_instr_i;
   logic [31:0] data_cache_data_i;
   logic [31:2] instr_cache_address_o;
   logic [31:2] data_cache_address_o;
   logic [3:0]  data_cache_write_en_o;
   logic [31:0] data_cache_data_o;
   logic        data_cache_enabled_o;

   logic [31:0] imem [0:255];
   logic [31:0] dmem [0:31];
   logic [31:0] model_mem [0:31];
   logic [31:0] regs [0:31]; // architectural state of the model
   store_t      exp_q [$];
   int          seed = 32'haa11;
   int          prog_len = 0;
   int          store_cnt = 0;
   int          exp_total = 0;
   logic        prog_ready = 1'b0;

   core DUT (.*);

   always #5 clk_i = ~clk_i;

   assign instr_cache_instr_i = imem[instr_cache_address_o[9:2]][31:2];
   assign data_cache_data_i   = dmem[data_cache_address_o[6:2]];

   function automatic int unsigned rnd_below(input int unsigned n);
      return {$random(seed)} % n;
   endfunction

   function automatic logic [31:0] fill_word(input int idx);
      return 32'h5a3c_0000 ^ (idx * 32'h0101_0107);
   endfunction

   function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
   endfunction

   function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
   endfunction

   task automatic check(input string name, input logic [63:0] expected,
                        input logic [63:0] actual);
      if (expected !== actual) begin
         $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
         $display("Finished with errors");
         $fatal(1, "mismatch in %s", name);
      end
   endtask

   task automatic emit(input logic [31:0] ins);
      imem[prog_len] = ins;
      prog_len++;
   endtask

   task automatic build_program();
      int unsigned kind;
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      for (int i = 0; i < 256; i++) begin
         imem[i] = 32'h0000_0013; // nop past the end
      end
      for (int r = 1; r < 8; r++) begin
         emit({20'(rnd_below(1 << 20)), 5'(r), 7'b0110111});
         emit(i_type(12'(rnd_below(4096)), 5'(r), 3'b000, 5'(r), 7'b0010011));
      end
      for (int k = 0; k < N_RANDOM; k++) begin
         kind = rnd_below(11);
         rd   = 5'(rnd_below(8));
         rs1  = 5'(rnd_below(8));
         rs2  = 5'(rnd_below(8));
         case (kind)
            0: emit(r_type(7'h00, rs2, rs1, 3'b000, rd));
            1: emit(r_type(7'h20, rs2, rs1, 3'b000, rd)); // sub
            2: emit(r_type(7'h00, rs2, rs1, 3'b111, rd));
            3: emit(r_type(7'h00, rs2, rs1, 3'b110, rd));
            4: emit(r_type(7'h00, rs2, rs1, 3'b100, rd));
            5: emit(r_type(7'h00, rs2, rs1, 3'b010, rd));
            6: emit(i_type(12'(rnd_below(4096)), rs1, 3'b000, rd, 7'b0010011));
            7: emit(i_type(12'(4 * rnd_below(16)), 5'd0, 3'b010, rd, 7'b0000011));
            8: emit(i_type(12'(rnd_below(64)), 5'd0, 3'b100, rd, 7'b0000011)); // lbu
            9: emit(s_type(12'(4 * rnd_below(16)), rs2, 5'd0, 3'b010));
            default: emit(s_type(12'(rnd_below(64)), rs2, 5'd0, 3'b000));
         endcase
      end
      emit(b_type(13'd12, 5'd1, 5'd1, 3'b000)); // beq taken over two
      emit(s_type(12'd0, 5'd2, 5'd0, 3'b010));
      emit(i_type(12'd1, 5'd3, 3'b000, 5'd3, 7'b0010011));
      emit(b_type(13'd8, 5'd2, 5'd2, 3'b001)); // bne never taken
      emit(i_type(12'd5, 5'd4, 3'b000, 5'd4, 7'b0010011));
      emit(j_type(21'd8, 5'd6)); // link into x6
      emit(s_type(12'd4, 5'd7, 5'd0, 3'b010));
      emit(r_type(7'h00, 5'd4, 5'd6, 3'b000, 5'd7));
      for (int r = 0; r < 8; r++) begin
         emit(s_type(12'(64 + 4 * r), 5'(r), 5'd0, 3'b010));
      end
      emit(j_type(21'd0, 5'd0)); // self-loop
   endtask

   // sequential interpreter over imem
   task automatic run_model();
      logic [31:0] pc;
      logic [31:0] ins;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] res;
      logic [31:0] ea;
      logic [31:0] nxt;
      logic        wr;
      store_t      st;
      for (int i = 0; i < 32; i++) begin
         regs[i]      = '0;
         model_mem[i] = fill_word(i);
      end
      pc  = '0;
      ins = imem[0];
      for (int step = 0; step < 1024 && ins != 32'h0000_006f; step++) begin
         a   = regs[ins[19:15]];
         b   = regs[ins[24:20]];
         nxt = pc + 32'd4;
         res = '0;
         wr  = 1'b0;
         case (ins[6:0])
            7'b0110011: begin
               wr = 1'b1;
               case (ins[14:12])
                  3'b000:  res = ins[30] ? a - b : a + b;
                  3'b010:  res = {31'd0, $signed(a) < $signed(b)};
                  3'b100:  res = a ^ b;
                  3'b110:  res = a | b;
                  default: res = a & b;
               endcase
            end
            7'b0010011: begin
               wr  = 1'b1;
               res = a + {{20{ins[31]}}, ins[31:20]};
            end
            7'b0110111: begin
               wr  = 1'b1;
               res = {ins[31:12], 12'd0};
            end
            7'b0000011: begin
               wr  = 1'b1;
               ea  = a + {{20{ins[31]}}, ins[31:20]};
               res = model_mem[ea[6:2]];
               if (ins[14:12] == 3'b100) begin
                  res = {24'd0, res[8 * ea[1:0] +: 8]};
               end
            end
            7'b0100011: begin
               ea      = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
               st.addr = ea[31:2];
               st.be   = (ins[14:12] == 3'b000) ? 4'b0001 << ea[1:0] : 4'b1111;
               st.data = (ins[14:12] == 3'b000) ? {4{b[7:0]}} : b; // byte on every lane
               for (int l = 0; l < 4; l++) begin
                  if (st.be[l]) begin
                     model_mem[ea[6:2]][8 * l +: 8] = st.data[8 * l +: 8];
                  end
               end
               exp_q.push_back(st);
            end
            7'b1100011: begin
               if ((a == b) != ins[12]) begin
                  nxt = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
               end
            end
            7'b1101111: begin
               wr  = 1'b1;
               res = pc + 32'd4;
               nxt = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            default: ;
         endcase
         if (wr && ins[11:7] != 5'd0) begin
            regs[ins[11:7]] = res;
         end
         pc  = nxt;
         ins = imem[pc[9:2]];
      end
      exp_total = exp_q.size();
   endtask

   // blocking pattern for both caches
   always @(posedge clk_i) begin
      #1;
      instr_cache_blocking_n_i = (rnd_below(4) != 0);
      data_cache_blocking_n_i  = (rnd_below(4) != 0);
   end

   // data cache model that writes a store on a cycle without blocking
   initial begin
      store_t want;
      for (int i = 0; i < 32; i++) begin
         dmem[i] = fill_word(i);
      end
      forever begin
         @(negedge clk_i);
         if (arst_n_i && data_cache_enabled_o && data_cache_blocking_n_i &&
             data_cache_write_en_o != 4'b0000) begin
            if (exp_q.size() == 0) begin
               $display("store to word %h completed but the model has no store left",
                        data_cache_address_o);
               $display("Finished with errors");
               $fatal(1, "unexpected store");
            end else begin
               want = exp_q.pop_front();
               check("store address", 64'(want.addr), 64'(data_cache_address_o));
               check("store byte enables", 64'(want.be), 64'(data_cache_write_en_o));
               check("store data", 64'(want.data), 64'(data_cache_data_o));
               for (int l = 0; l < 4; l++) begin
                  if (data_cache_write_en_o[l]) begin
                     dmem[data_cache_address_o[6:2]][8 * l +: 8] = data_cache_data_o[8 * l +: 8];
                  end
               end
               store_cnt++;
            end
         end
      end
   end

   initial begin
      wait (prog_ready);
      repeat (prog_len * 20) @(posedge clk_i);
      $display("timeout after %0d cycles, the program did not finish", prog_len * 20);
      $display("Finished with errors");
      $fatal(1, "watchdog expired");
   end

   initial begin
      arst_n_i = 1'b0;
      build_program();
      run_model();
      prog_ready = 1'b1;
      repeat (16) begin
         @(posedge clk_i);
         check("reset dcache enable", 64'd0, 64'(data_cache_enabled_o));
         check("reset write enables", 64'd0, 64'(data_cache_write_en_o));
         check("reset fetch address", 64'd0, 64'(instr_cache_address_o));
      end
      #1;
      arst_n_i = 1'b1;
      wait (instr_cache_address_o == 30'(prog_len - 1)); // fetch reached the self-loop
      repeat (20) @(posedge clk_i); // stores still in flight drain
      for (int i = 0; i < 32; i++) begin
         check($sformatf("final memory word %0d", i), 64'(model_mem[i]), 64'(dmem[i]));
      end
      check("store count", 64'(exp_total), 64'(store_cnt));
      $display("Finished with no errors");
      $finish;
   end

endmodule

// ==== files.f ====
src/rv_isa_pkg.sv
src/core_pipe_pkg.sv
src/pipe_reg.sv
src/fetch_stage.sv
src/reg_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/core.sv
testbench/core_checker.sv
testbench/core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := core_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
